// ==== project.f ====
mist_ctrl_pkg.sv
status_regs.sv
key_decoder.sv
control_mapper.sv
sigma_delta_dac.sv
mist_ctrl_top.sv
tb_mist_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_mist_ctrl -f project.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

grep -q "All tests passed" sim.log
if [ $? -ne 0 ]; then
	echo "pass message not found in sim.log"
	exit 1
fi

exit 0

// ==== tb_mist_ctrl.sv ====
module tb_mist_ctrl;

	localparam int addr_w  = 4;
	localparam int audio_w = 8;
	// dac runs take about 1100 cycles and the other tests fewer
	localparam int timeout_cycles = 3000;
	localparam logic [addr_w-1:0] a_status   = addr_w'(mist_ctrl_pkg::addr_status);
	localparam logic [addr_w-1:0] a_controls = addr_w'(mist_ctrl_pkg::addr_controls);
	localparam logic [addr_w-1:0] a_unmapped = 4'h8;

	logic clk_mist;
	logic rst_n;
	logic awvalid, awready, wvalid, wready, bvalid, bready, arvalid, arready, rvalid, rready;
	logic [addr_w-1:0] awaddr, araddr;
	logic [31:0] wdata, rdata;
	logic [3:0]  wstrb;
	logic [1:0]  bresp, rresp;
	logic key_strobe, key_pressed;
	logic [7:0] key_code, joystick_0, joystick_1;
	logic board_reset_btn;
	logic [audio_w-1:0] audio_in;
	logic audio_l, audio_r, game_rst_n;
	logic coin_n, start1_n, start2_n, fire_n, move_left_n, move_right_n;
	logic [1:0] scanlines;

	integer seed = 11178;
	int cycles = 0;

	mist_ctrl_top #(
		.addr_w(addr_w),
		.audio_w(audio_w)
	) dut0 (.*);

	initial begin
		clk_mist = 1'b0;
		forever #2 clk_mist = ~clk_mist;
	end

	always @(posedge clk_mist) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
			$display("Some tests failed");
			$fatal(1);
		end
	end

	task automatic check_eq(input string test, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (expected === actual) else begin
			$display("ERROR %s expected %h actual %h", test, expected, actual);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_mist);
	endtask

	function automatic logic [31:0] controls_now();
		return {26'b0, coin_n, start1_n, start2_n, fire_n, move_left_n, move_right_n};
	endfunction

	task automatic axi_write(input logic [addr_w-1:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [1:0] resp);
		@(posedge clk_mist);
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		awaddr  <= addr;
		wdata   <= data;
		wstrb   <= strb;
		bready  <= 1'b1;
		do @(negedge clk_mist); while (!(awready && wready));
		@(posedge clk_mist); // accept edge
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		do @(negedge clk_mist); while (!bvalid);
		resp = bresp;
		@(posedge clk_mist);
	endtask

	task automatic axi_read(input logic [addr_w-1:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		@(posedge clk_mist);
		arvalid <= 1'b1;
		araddr  <= addr;
		rready  <= 1'b1;
		do @(negedge clk_mist); while (!arready);
		@(posedge clk_mist);
		arvalid <= 1'b0;
		do @(negedge clk_mist); while (!rvalid);
		data = rdata;
		resp = rresp;
		@(posedge clk_mist);
	endtask

	task automatic send_key(input logic [7:0] code, input logic pressed);
		@(posedge clk_mist);
		key_strobe  <= 1'b1;
		key_code    <= code;
		key_pressed <= pressed;
		@(posedge clk_mist); // decoder takes it here
		key_strobe  <= 1'b0;
	endtask

	// press, check two cycles later, release
	task automatic key_effect(input string test, input logic [7:0] code,
			input logic [31:0] expected);
		send_key(code, 1'b1);
		@(posedge clk_mist);
		@(negedge clk_mist);
		check_eq(test, expected, controls_now());
		send_key(code, 1'b0);
		@(posedge clk_mist);
		@(negedge clk_mist);
		check_eq(test, 32'h3F, controls_now());
	endtask

	task automatic test_reset_state();
		logic [31:0] d;
		logic [1:0]  r;
		@(negedge clk_mist);
		check_eq("reset_state", 32'h3F, controls_now());
		check_eq("reset_state", 32'h1, 32'(game_rst_n));
		check_eq("reset_state", 32'h0, 32'(scanlines));
		axi_read(a_status, d, r);
		check_eq("reset_state", 32'h0, d);
		check_eq("reset_state", 32'(mist_ctrl_pkg::resp_okay), 32'(r));
		axi_read(a_controls, d, r);
		check_eq("reset_state", 32'h3F, d);
		check_eq("reset_state", 32'(mist_ctrl_pkg::resp_okay), 32'(r));
	endtask

	task automatic test_status_rw();
		logic [31:0] expected;
		logic [31:0] data;
		logic [31:0] d;
		logic [3:0]  strb;
		logic [1:0]  r;
		expected = '0;
		for (int n = 0; n < 8; n++) begin
			data = $random(seed);
			strb = 4'($random(seed));
			for (int i = 0; i < 4; i++) begin
				if (strb[i]) expected[8*i +: 8] = data[8*i +: 8];
			end
			axi_write(a_status, data, strb, r);
			check_eq("status_rw", 32'(mist_ctrl_pkg::resp_okay), 32'(r));
			axi_read(a_status, d, r);
			check_eq("status_rw", expected, d);
			@(negedge clk_mist);
			check_eq("status_rw", 32'(expected[4:3]), 32'(scanlines));
			check_eq("status_rw", 32'(!(expected[0] || expected[6])), 32'(game_rst_n));
		end
		axi_write(a_status, 32'h40, 4'hF, r);
		@(negedge clk_mist);
		check_eq("status_rw", 32'h0, 32'(game_rst_n));
		axi_write(a_status, 32'h0, 4'hF, r);
		@(negedge clk_mist);
		check_eq("status_rw", 32'h1, 32'(game_rst_n));
		@(posedge clk_mist);
		board_reset_btn <= 1'b1;
		wait_cycles(2);
		@(negedge clk_mist);
		check_eq("status_rw", 32'h0, 32'(game_rst_n));
		board_reset_btn <= 1'b0;
		wait_cycles(2);
		@(negedge clk_mist);
		check_eq("status_rw", 32'h1, 32'(game_rst_n));
	endtask

	task automatic test_keys_rotation();
		logic [1:0] r;
		send_key(mist_ctrl_pkg::key_up, 1'b1);
		@(negedge clk_mist); // not yet there one cycle after the strobe
		check_eq("keys_rotation", 32'h1, 32'(move_left_n));
		@(posedge clk_mist);
		@(negedge clk_mist);
		check_eq("keys_rotation", 32'h0, 32'(move_left_n));
		send_key(mist_ctrl_pkg::key_up, 1'b0);
		@(posedge clk_mist);
		@(negedge clk_mist);
		check_eq("keys_rotation", 32'h1, 32'(move_left_n));
		axi_write(a_status, 32'h1 << mist_ctrl_pkg::st_rotate, 4'h1, r);
		key_effect("keys_rotation", mist_ctrl_pkg::key_left, 32'h3D);
		key_effect("keys_rotation", mist_ctrl_pkg::key_right, 32'h3E);
		key_effect("keys_rotation", mist_ctrl_pkg::key_esc, 32'h1F);
		key_effect("keys_rotation", mist_ctrl_pkg::key_f1, 32'h2F);
		key_effect("keys_rotation", mist_ctrl_pkg::key_f2, 32'h37);
		key_effect("keys_rotation", mist_ctrl_pkg::key_space, 32'h3B);
		key_effect("keys_rotation", 8'h1C, 32'h3F);
		key_effect("keys_rotation", 8'hF0, 32'h3F);
		axi_write(a_status, 32'h0, 4'hF, r);
	endtask

	task automatic test_joysticks();
		logic [1:0] r;
		logic [7:0] j0;
		logic [7:0] j1;
		logic rot;
		logic [31:0] expected;
		for (int k = 0; k < 2; k++) begin
			rot = 1'(k);
			axi_write(a_status, 32'(rot) << mist_ctrl_pkg::st_rotate, 4'h1, r);
			for (int n = 0; n < 10; n++) begin
				j0 = 8'($random(seed));
				j1 = 8'($random(seed));
				@(posedge clk_mist);
				joystick_0 <= j0;
				joystick_1 <= j1;
				@(posedge clk_mist);
				@(negedge clk_mist);
				expected = 32'h38;
				expected[2] = ~(j0[4] | j1[4]);
				expected[1] = rot ? ~(j0[1] | j1[1]) : ~(j0[3] | j1[3]);
				expected[0] = rot ? ~(j0[0] | j1[0]) : ~(j0[2] | j1[2]);
				check_eq("joysticks", expected, controls_now());
			end
		end
		@(posedge clk_mist);
		joystick_0 <= '0;
		joystick_1 <= '0;
		axi_write(a_status, 32'h0, 4'hF, r);
	endtask

	task automatic test_axi_errors_backpressure();
		logic [31:0] d;
		logic [1:0]  r;
		axi_write(a_status, 32'h0000_0018, 4'hF, r);
		axi_write(a_controls, 32'hFFFF_FFFF, 4'hF, r);
		check_eq("axi_errors", 32'(mist_ctrl_pkg::resp_slverr), 32'(r));
		axi_write(a_unmapped, 32'hFFFF_FFFF, 4'hF, r);
		check_eq("axi_errors", 32'(mist_ctrl_pkg::resp_slverr), 32'(r));
		axi_read(a_unmapped, d, r);
		check_eq("axi_errors", 32'(mist_ctrl_pkg::resp_slverr), 32'(r));
		check_eq("axi_errors", 32'h0, d);
		axi_read(a_status, d, r);
		check_eq("axi_errors", 32'h18, d);

		// write response held back
		@(posedge clk_mist);
		bready  <= 1'b0;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		awaddr  <= a_status;
		wdata   <= 32'h0000_0008;
		wstrb   <= 4'hF;
		do @(negedge clk_mist); while (!awready);
		@(posedge clk_mist);
		wdata   <= 32'h0000_0010; // second write waits behind it
		wait_cycles(4);
		@(negedge clk_mist);
		check_eq("backpressure", 32'h1, 32'(bvalid));
		check_eq("backpressure", 32'h0, 32'(awready));
		check_eq("backpressure", 32'h0, 32'(wready));
		check_eq("backpressure", 32'h1, 32'(scanlines));
		@(posedge clk_mist);
		bready <= 1'b1;
		do @(negedge clk_mist); while (!awready);
		@(posedge clk_mist);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		wait_cycles(2);
		@(negedge clk_mist);
		check_eq("backpressure", 32'h2, 32'(scanlines));

		// read response held back
		@(posedge clk_mist);
		rready  <= 1'b0;
		arvalid <= 1'b1;
		araddr  <= a_status;
		do @(negedge clk_mist); while (!arready);
		@(posedge clk_mist);
		araddr  <= a_controls;
		wait_cycles(4);
		@(negedge clk_mist);
		check_eq("backpressure", 32'h1, 32'(rvalid));
		check_eq("backpressure", 32'h0, 32'(arready));
		check_eq("backpressure", 32'h10, rdata);
		@(posedge clk_mist);
		rready <= 1'b1;
		do @(negedge clk_mist); while (!arready);
		@(posedge clk_mist);
		arvalid <= 1'b0;
		do @(negedge clk_mist); while (!rvalid);
		check_eq("backpressure", 32'h3F, rdata);
		@(posedge clk_mist);
		axi_write(a_status, 32'h0, 4'hF, r);
	endtask

	task automatic test_dac_density();
		logic [audio_w-1:0] level;
		int ones;
		for (int n = 0; n < 4; n++) begin
			level = audio_w'($random(seed));
			@(posedge clk_mist);
			audio_in <= level;
			rst_n    <= 1'b0;
			wait_cycles(2);
			rst_n    <= 1'b1;
			ones = 0;
			repeat (256) begin
				@(negedge clk_mist);
				check_eq("dac_density", 32'(audio_l), 32'(audio_r));
				if (audio_l) ones++;
			end
			assert ((ones - int'(level)) <= 1 && (int'(level) - ones) <= 1) else begin
				$display("ERROR dac_density expected %0d actual %0d", level, ones);
				$display("Some tests failed");
				$fatal(1);
			end
		end
	endtask

	initial begin
		rst_n = 1'b0;
		awvalid = 1'b0;
		wvalid = 1'b0;
		awaddr = '0;
		wdata = '0;
		wstrb = '0;
		bready = 1'b1;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b1;
		key_strobe = 1'b0;
		key_pressed = 1'b0;
		key_code = '0;
		joystick_0 = '0;
		joystick_1 = '0;
		board_reset_btn = 1'b0;
		audio_in = '0;
		repeat (8) @(posedge clk_mist);
		rst_n <= 1'b1;
		test_reset_state();
		test_status_rw();
		test_keys_rotation();
		test_joysticks();
		test_axi_errors_backpressure();
		test_dac_density();
		$display("All tests passed");
		$finish;
	end

endmodule

// ==== mist_ctrl_top.sv ====
module mist_ctrl_top #(
	parameter int addr_w  = 4,
	parameter int audio_w = 8
) (
	input  logic               clk_mist,
	input  logic               rst_n,

	input  logic               awvalid,
	output logic               awready,
	input  logic [addr_w-1:0]  awaddr,
	input  logic               wvalid,
	output logic               wready,
	input  logic [31:0]        wdata,
	input  logic [3:0]         wstrb,
	output logic               bvalid,
	input  logic               bready,
	output logic [1:0]         bresp,
	input  logic               arvalid,
	output logic               arready,
	input  logic [addr_w-1:0]  araddr,
	output logic               rvalid,
	input  logic               rready,
	output logic [31:0]        rdata,
	output logic [1:0]         rresp,

	input  logic               key_strobe,
	input  logic               key_pressed,
	input  logic [7:0]         key_code,
	input  logic [7:0]         joystick_0,
	input  logic [7:0]         joystick_1,
	input  logic               board_reset_btn,

	input  logic [audio_w-1:0] audio_in,
	output logic               audio_l,
	output logic               audio_r,

	output logic               game_rst_n,
	output logic               coin_n,
	output logic               start1_n,
	output logic               start2_n,
	output logic               fire_n,
	output logic               move_left_n,
	output logic               move_right_n,
	output logic [1:0]         scanlines
);

	logic                             rotate;
	logic [mist_ctrl_pkg::num_btn-1:0] key_state;

	status_regs #(
		.addr_w(addr_w)
	) u_status_regs (
		.clk_mist        (clk_mist),
		.rst_n           (rst_n),
		.awvalid         (awvalid),
		.awready         (awready),
		.awaddr          (awaddr),
		.wvalid          (wvalid),
		.wready          (wready),
		.wdata           (wdata),
		.wstrb           (wstrb),
		.bvalid          (bvalid),
		.bready          (bready),
		.bresp           (bresp),
		.arvalid         (arvalid),
		.arready         (arready),
		.araddr          (araddr),
		.rvalid          (rvalid),
		.rready          (rready),
		.rdata           (rdata),
		.rresp           (rresp),
		.board_reset_btn (board_reset_btn),
		.coin_n          (coin_n),
		.start1_n        (start1_n),
		.start2_n        (start2_n),
		.fire_n          (fire_n),
		.move_left_n     (move_left_n),
		.move_right_n    (move_right_n),
		.rotate          (rotate),
		.scanlines       (scanlines),
		.game_rst_n      (game_rst_n)
	);

	key_decoder u_key_decoder (
		.clk_mist    (clk_mist),
		.rst_n       (rst_n),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.key_state   (key_state)
	);

	control_mapper u_control_mapper (
		.clk_mist     (clk_mist),
		.rst_n        (rst_n),
		.key_state    (key_state),
		.joystick_0   (joystick_0),
		.joystick_1   (joystick_1),
		.rotate       (rotate),
		.coin_n       (coin_n),
		.start1_n     (start1_n),
		.start2_n     (start2_n),
		.fire_n       (fire_n),
		.move_left_n  (move_left_n),
		.move_right_n (move_right_n)
	);

	sigma_delta_dac #(
		.audio_w(audio_w)
	) u_dac (
		.clk_mist (clk_mist),
		.rst_n    (rst_n),
		.audio_in (audio_in),
		.dac_out  (audio_l)
	);

	assign audio_r = audio_l; // mono game audio

endmodule

// ==== sigma_delta_dac.sv ====
module sigma_delta_dac #(
	parameter int audio_w = 8
) (
	input  logic               clk_mist,
	input  logic               rst_n,
	input  logic [audio_w-1:0] audio_in,
	output logic               dac_out
);

	logic [audio_w-1:0] acc;
	logic [audio_w:0]   sum; // top bit is the carry

	assign sum = {1'b0, acc} + {1'b0, audio_in};

	always_ff @(posedge clk_mist or negedge rst_n) begin
		if (!rst_n) begin
			acc     <= '0;
			dac_out <= 1'b0;
		end else begin
			acc     <= sum[audio_w-1:0];
			dac_out <= sum[audio_w];
		end
	end

endmodule

// ==== control_mapper.sv ====
module control_mapper (
	input  logic                             clk_mist,
	input  logic                             rst_n,
	input  logic [mist_ctrl_pkg::num_btn-1:0] key_state,
	input  logic [7:0]                       joystick_0,
	input  logic [7:0]                       joystick_1,
	input  logic                             rotate,
	output logic                             coin_n,
	output logic                             start1_n,
	output logic                             start2_n,
	output logic                             fire_n,
	output logic                             move_left_n,
	output logic                             move_right_n
);

	logic m_right;
	logic m_left;
	logic m_down;
	logic m_up;
	logic m_fire;
	logic game_left;
	logic game_right;

	// key or either joystick
	assign m_right = key_state[mist_ctrl_pkg::btn_right] | joystick_0[0] | joystick_1[0];
	assign m_left  = key_state[mist_ctrl_pkg::btn_left]  | joystick_0[1] | joystick_1[1];
	assign m_down  = key_state[mist_ctrl_pkg::btn_down]  | joystick_0[2] | joystick_1[2];
	assign m_up    = key_state[mist_ctrl_pkg::btn_up]    | joystick_0[3] | joystick_1[3];
	assign m_fire  = key_state[mist_ctrl_pkg::btn_fire1] | joystick_0[4] | joystick_1[4];

	// cabinet is vertical, so unrotated play moves on up/down
	assign game_left  = rotate ? m_left  : m_up;
	assign game_right = rotate ? m_right : m_down;

	always_ff @(posedge clk_mist or negedge rst_n) begin
		if (!rst_n) begin
			coin_n       <= 1'b1;
			start1_n     <= 1'b1;
			start2_n     <= 1'b1;
			fire_n       <= 1'b1;
			move_left_n  <= 1'b1;
			move_right_n <= 1'b1;
		end else begin
			coin_n       <= ~key_state[mist_ctrl_pkg::btn_coin];
			start1_n     <= ~key_state[mist_ctrl_pkg::btn_start1];
			start2_n     <= ~key_state[mist_ctrl_pkg::btn_start2];
			fire_n       <= ~m_fire;
			move_left_n  <= ~game_left;
			move_right_n <= ~game_right;
		end
	end

endmodule

// ==== key_decoder.sv ====
module key_decoder (
	input  logic                             clk_mist,
	input  logic                             rst_n,
	input  logic                             key_strobe,
	input  logic                             key_pressed,
	input  logic [7:0]                       key_code,
	output logic [mist_ctrl_pkg::num_btn-1:0] key_state
);

	// one held bit per mapped key
	always_ff @(posedge clk_mist or negedge rst_n) begin
		if (!rst_n) begin
			key_state <= '0;
		end else if (key_strobe) begin
			case (key_code)
				mist_ctrl_pkg::key_up: begin
					key_state[mist_ctrl_pkg::btn_up] <= key_pressed;
				end
				mist_ctrl_pkg::key_down: begin
					key_state[mist_ctrl_pkg::btn_down] <= key_pressed;
				end
				mist_ctrl_pkg::key_left: begin
					key_state[mist_ctrl_pkg::btn_left] <= key_pressed;
				end
				mist_ctrl_pkg::key_right: begin
					key_state[mist_ctrl_pkg::btn_right] <= key_pressed;
				end
				mist_ctrl_pkg::key_esc: begin
					key_state[mist_ctrl_pkg::btn_coin] <= key_pressed; // coin
				end
				mist_ctrl_pkg::key_f1: begin
					key_state[mist_ctrl_pkg::btn_start1] <= key_pressed;
				end
				mist_ctrl_pkg::key_f2: begin
					key_state[mist_ctrl_pkg::btn_start2] <= key_pressed;
				end
				mist_ctrl_pkg::key_space: begin
					key_state[mist_ctrl_pkg::btn_fire1] <= key_pressed;
				end
				mist_ctrl_pkg::key_alt: begin
					key_state[mist_ctrl_pkg::btn_fire2] <= key_pressed;
				end
				mist_ctrl_pkg::key_ctrl: begin
					key_state[mist_ctrl_pkg::btn_fire3] <= key_pressed;
				end
				default: begin
					key_state <= key_state;
				end
			endcase
		end
	end

endmodule

// ==== status_regs.sv ====
module status_regs #(
	parameter int addr_w = 4
) (
	input  logic              clk_mist,
	input  logic              rst_n,

	input  logic              awvalid,
	output logic              awready,
	input  logic [addr_w-1:0] awaddr,
	input  logic              wvalid,
	output logic              wready,
	input  logic [31:0]       wdata,
	input  logic [3:0]        wstrb,
	output logic              bvalid,
	input  logic              bready,
	output logic [1:0]        bresp,
	input  logic              arvalid,
	output logic              arready,
	input  logic [addr_w-1:0] araddr,
	output logic              rvalid,
	input  logic              rready,
	output logic [31:0]       rdata,
	output logic [1:0]        rresp,

	input  logic              board_reset_btn,
	input  logic              coin_n,
	input  logic              start1_n,
	input  logic              start2_n,
	input  logic              fire_n,
	input  logic              move_left_n,
	input  logic              move_right_n,

	output logic              rotate,
	output logic [1:0]        scanlines,
	output logic              game_rst_n
);

	logic        ready_en; // low only while in reset
	logic [31:0] status;
	logic        wr_hs;
	logic        rd_hs;
	logic        wr_is_status;
	logic        rd_is_status;
	logic        rd_is_controls;
	logic [31:0] rd_word;

	assign wr_is_status   = (awaddr == addr_w'(mist_ctrl_pkg::addr_status));
	assign rd_is_status   = (araddr == addr_w'(mist_ctrl_pkg::addr_status));
	assign rd_is_controls = (araddr == addr_w'(mist_ctrl_pkg::addr_controls));

	// address and data are taken together in one beat
	assign awready = ready_en & awvalid & wvalid & ~bvalid;
	assign wready  = awready;
	assign arready = ready_en & ~rvalid;

	assign wr_hs = awvalid & awready;
	assign rd_hs = arvalid & arready;

	always_ff @(posedge clk_mist or negedge rst_n) begin
		if (!rst_n) begin
			ready_en <= 1'b0;
		end else begin
			ready_en <= 1'b1;
		end
	end

	always_ff @(posedge clk_mist or negedge rst_n) begin
		if (!rst_n) begin
			status <= '0;
		end else if (wr_hs && wr_is_status) begin
			for (int i = 0; i < 4; i++) begin
				if (wstrb[i]) begin
					status[8*i +: 8] <= wdata[8*i +: 8];
				end
			end
		end
	end

	// write response channel
	always_ff @(posedge clk_mist or negedge rst_n) begin
		if (!rst_n) begin
			bvalid <= 1'b0;
			bresp  <= mist_ctrl_pkg::resp_okay;
		end else if (wr_hs) begin
			bvalid <= 1'b1;
			bresp  <= wr_is_status ? mist_ctrl_pkg::resp_okay : mist_ctrl_pkg::resp_slverr;
		end else if (bready) begin
			bvalid <= 1'b0;
		end
	end

	always_comb begin
		rd_word = '0; // unmapped reads as zero
		if (rd_is_status) begin
			rd_word = status;
		end else if (rd_is_controls) begin
			rd_word[5:0] = {coin_n, start1_n, start2_n, fire_n, move_left_n, move_right_n};
		end
	end

	// read response channel
	always_ff @(posedge clk_mist or negedge rst_n) begin
		if (!rst_n) begin
			rvalid <= 1'b0;
			rresp  <= mist_ctrl_pkg::resp_okay;
		end else if (rd_hs) begin
			rvalid <= 1'b1;
			rresp  <= (rd_is_status || rd_is_controls) ? mist_ctrl_pkg::resp_okay
			                                           : mist_ctrl_pkg::resp_slverr;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk_mist) begin
		if (rd_hs) begin
			rdata <= rd_word; // held until rready
		end
	end

	assign rotate    = status[mist_ctrl_pkg::st_rotate];
	assign scanlines = status[mist_ctrl_pkg::st_scan_hi:mist_ctrl_pkg::st_scan_lo];

	always_ff @(posedge clk_mist or negedge rst_n) begin
		if (!rst_n) begin
			game_rst_n <= 1'b1; // status word starts clear
		end else begin
			game_rst_n <= ~(status[mist_ctrl_pkg::st_reset] |
			                status[mist_ctrl_pkg::st_reset_trig] |
			                board_reset_btn);
		end
	end

endmodule

// ==== mist_ctrl_pkg.sv ====
package mist_ctrl_pkg;

	// ps/2 set 2 scan codes
	localparam logic [7:0] key_up    = 8'h75;
	localparam logic [7:0] key_down  = 8'h72;
	localparam logic [7:0] key_left  = 8'h6B;
	localparam logic [7:0] key_right = 8'h74;
	localparam logic [7:0] key_esc   = 8'h76;
	localparam logic [7:0] key_f1    = 8'h05;
	localparam logic [7:0] key_f2    = 8'h06;
	localparam logic [7:0] key_ctrl  = 8'h14;
	localparam logic [7:0] key_alt   = 8'h11;
	localparam logic [7:0] key_space = 8'h29;

	// positions in the held key vector
	localparam int btn_up     = 0;
	localparam int btn_down   = 1;
	localparam int btn_left   = 2;
	localparam int btn_right  = 3;
	localparam int btn_coin   = 4;
	localparam int btn_start1 = 5;
	localparam int btn_start2 = 6;
	localparam int btn_fire1  = 7;
	localparam int btn_fire2  = 8;
	localparam int btn_fire3  = 9;
	localparam int num_btn    = 10;

	// status word bits
	localparam int st_reset      = 0;
	localparam int st_rotate     = 2;
	localparam int st_scan_lo    = 3;
	localparam int st_scan_hi    = 4;
	localparam int st_reset_trig = 6;

	// register map, byte addresses
	localparam int unsigned addr_status   = 'h0;
	localparam int unsigned addr_controls = 'h4; // read only

	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

endpackage
